// ==== project.f ====
+incdir+.
mips_pkg.sv
stage_reg.sv
alu_stage.sv
mem_stage.sv
ex_mem_top.sv
ex_mem_sva.sv
ex_mem_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ex_mem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module ex_mem_tb -Mdir obj_dir -f project.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

./obj_dir/Vex_mem_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

// ==== ex_mem_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_cfg.svh"

module ex_mem_tb
    import mips_pkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int N_DIRECTED      = 40;   // upper bound on the directed list
    localparam int N_RAND_TIMED    = 150;
    localparam int N_RAND_NOISY    = 350;
    localparam int N_OPS           = N_DIRECTED + N_RAND_TIMED + N_RAND_NOISY;
    localparam int WATCHDOG_CYCLES = N_OPS * 16 + 100;  // worst stall per op, reset, drain

    logic                   clk_i = 1'b0;
    logic                   rst_i;
    logic                   flush_i;
    logic                   iss_valid_i;
    alu_op_e                iss_op_i;
    logic [`DATA_W-1:0]     iss_a_i;
    logic [`DATA_W-1:0]     iss_b_i;
    logic [`REG_ADDR_W-1:0] iss_dest_i;
    logic                   iss_we_i;
    logic [`DATA_W-1:0]     iss_pc_i;
    logic                   iss_ready_o;
    logic                   wb_valid_o;
    logic [`REG_ADDR_W-1:0] wb_dest_o;
    logic                   wb_we_o;
    logic [`DATA_W-1:0]     wb_data_o;
    logic [`DATA_W-1:0]     wb_pc_o;
    exc_e                   wb_exc_o;
    logic                   wb_ready_i;

    issue_pkt_t         pending[$];   // not yet offered to the DUT
    issue_pkt_t         exp_q[$];     // accepted, not yet retired
    int                 acc_q[$];     // acceptance edge, -1 when untimed
    logic [`DATA_W-1:0] ram [`DMEM_DEPTH] = '{default: '0};
    logic [`DATA_W-1:0] hi = '0;
    logic [`DATA_W-1:0] lo = '0;
    logic [`DATA_W-1:0] next_pc = '0;
    int                 edge_cnt = 0;
    int                 squash_cnt = 0;
    bit                 timed_phase = 1'b0;
    bit                 iss_fire = 1'b0;

    ex_mem_top dut (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic abort_run(input string why);
        $display("TEST FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic report_mismatch(input string name, input logic [`DATA_W-1:0] exp_v,
                                   input logic [`DATA_W-1:0] act_v);
        $display("MISMATCH %s expected %h actual %h", name, exp_v, act_v);
        abort_run({"wrong value in ", name});
    endtask

    // program-order model, state advances as each record retires
    task automatic check_retire();
        issue_pkt_t         p;
        alu_op_e            op;
        int                 acc;
        longint             sa;
        longint             sb;
        longint             wide;
        logic [`DATA_W-1:0] addr;
        logic [`DATA_W-1:0] exp_data;
        logic               exp_we;
        exc_e               exp_exc;
        int                 idx;
        string              tag;
        assert (exp_q.size() > 0) else abort_run("a record retired with nothing outstanding");
        p        = exp_q.pop_front();
        acc      = acc_q.pop_front();
        op       = p.op;
        sa       = $signed(p.a);
        sb       = $signed(p.b);
        addr     = p.a + p.b;
        idx      = (addr / 4) % `DMEM_DEPTH;
        exp_exc  = EXC_NONE;
        exp_data = '0;
        tag      = $sformatf("%s pc %h", op.name(), p.pc);
        case (op)
            OP_ADD, OP_SUB: begin
                wide     = (op == OP_ADD) ? sa + sb : sa - sb;
                exp_data = wide[`DATA_W-1:0];
                if (wide != longint'($signed(wide[`DATA_W-1:0]))) begin
                    exp_exc = EXC_OV;  // does not fit 32 signed bits
                end
            end
            OP_AND:  exp_data = p.a & p.b;
            OP_OR:   exp_data = p.a | p.b;
            OP_XOR:  exp_data = p.a ^ p.b;
            OP_SLT:  exp_data = (sa < sb) ? 1 : 0;
            OP_MULT: begin
                wide     = sa * sb;
                hi       = wide[63:32];
                lo       = wide[31:0];
                exp_data = lo;
            end
            OP_MTHI: begin
                hi       = p.a;
                exp_data = p.a;
            end
            OP_MTLO: begin
                lo       = p.a;
                exp_data = p.a;
            end
            OP_MFHI: exp_data = hi;
            OP_MFLO: exp_data = lo;
            OP_LW: begin
                if (addr % 4 != 0) begin
                    exp_exc = EXC_ADEL;
                end else begin
                    exp_data = ram[idx];
                end
            end
            OP_SW: begin
                exp_data = addr;
                if (addr % 4 != 0) begin
                    exp_exc = EXC_ADES;
                end else begin
                    ram[idx] = p.b;
                end
            end
            default: abort_run("unknown operation in the expected queue");
        endcase
        exp_we = p.we && (exp_exc == EXC_NONE);
        assert (wb_exc_o == exp_exc) else report_mismatch({tag, " exc"}, exp_exc, wb_exc_o);
        assert (wb_we_o == exp_we) else report_mismatch({tag, " we"}, exp_we, wb_we_o);
        assert (wb_dest_o == p.dest) else report_mismatch({tag, " dest"}, p.dest, wb_dest_o);
        assert (wb_pc_o == p.pc) else report_mismatch({tag, " pc"}, p.pc, wb_pc_o);
        if (exp_exc == EXC_NONE) begin
            assert (wb_data_o == exp_data)
                else report_mismatch({tag, " data"}, exp_data, wb_data_o);
        end
        if (acc >= 0) begin
            assert (edge_cnt - acc == 3)
                else report_mismatch({tag, " latency"}, 3, edge_cnt - acc);
        end
    endtask

    always @(posedge clk_i) begin
        if (!rst_i) begin
            edge_cnt++;
            if (wb_valid_o && wb_ready_i) begin
                check_retire();
            end
            if (flush_i) begin
                // a stalled record at the writeback port survives
                while (exp_q.size() > ((wb_valid_o && !wb_ready_i) ? 1 : 0)) begin
                    void'(exp_q.pop_back());
                    void'(acc_q.pop_back());
                    squash_cnt++;
                end
            end else if (iss_valid_i && iss_ready_o) begin
                exp_q.push_back('{iss_op_i, iss_a_i, iss_b_i, iss_dest_i, iss_we_i, iss_pc_i});
                acc_q.push_back(timed_phase ? edge_cnt : -1);
            end
            iss_fire = iss_valid_i && iss_ready_o;
        end
    end

    task automatic queue_op(input alu_op_e op, input logic [`DATA_W-1:0] a,
                            input logic [`DATA_W-1:0] b);
        issue_pkt_t p;
        p.op   = op;
        p.a    = a;
        p.b    = b;
        p.dest = `REG_ADDR_W'($urandom_range(1, 31));
        p.we   = ($urandom_range(0, 7) != 0);
        p.pc   = next_pc;
        pending.push_back(p);
        next_pc += 4;
    endtask

    task automatic queue_random_op();
        int                 sel;
        logic [`DATA_W-1:0] x;
        logic [`DATA_W-1:0] y;
        logic [`DATA_W-1:0] addr;
        sel  = $urandom_range(0, 15);
        x    = $urandom;
        y    = $urandom;
        addr = $urandom_range(0, 15) * 4;
        if ($urandom_range(0, 7) == 0) begin
            addr += $urandom_range(1, 3);  // misaligned now and then
        end
        if (sel >= 13) begin
            sel = (sel == 15) ? int'(OP_SW) : int'(OP_LW);  // extra memory traffic
        end
        case (alu_op_e'(sel))
            OP_LW:   queue_op(OP_LW, addr, '0);
            OP_SW:   queue_op(OP_SW, addr - y, y);
            default: queue_op(alu_op_e'(sel), x, y);
        endcase
    endtask

    task automatic drive_ops(input bit noisy);
        issue_pkt_t p;
        while (pending.size() > 0 || iss_valid_i) begin
            @(negedge clk_i);
            if (iss_fire || !iss_valid_i) begin
                iss_valid_i = 1'b0;
                if (pending.size() > 0 && !(noisy && $urandom_range(0, 7) == 0)) begin
                    p           = pending.pop_front();
                    iss_valid_i = 1'b1;
                    iss_op_i    = p.op;
                    iss_a_i     = p.a;
                    iss_b_i     = p.b;
                    iss_dest_i  = p.dest;
                    iss_we_i    = p.we;
                    iss_pc_i    = p.pc;
                end
            end
            if (noisy) begin
                wb_ready_i = ($urandom_range(0, 3) != 0);
                flush_i    = ($urandom_range(0, 39) == 0);
            end
        end
        flush_i    = 1'b0;
        wb_ready_i = 1'b1;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0 || wb_valid_o) begin
            @(negedge clk_i);
        end
    endtask

    initial begin
        void'($urandom(32'heeb6_4f91));
        rst_i       = 1'b1;
        flush_i     = 1'b0;
        iss_valid_i = 1'b0;
        iss_op_i    = OP_ADD;
        iss_a_i     = '0;
        iss_b_i     = '0;
        iss_dest_i  = '0;
        iss_we_i    = 1'b0;
        iss_pc_i    = '0;
        wb_ready_i  = 1'b1;
        repeat (5) @(negedge clk_i);
        rst_i = 1'b0;

        queue_op(OP_ADD, 32'd5, 32'd7);
        queue_op(OP_ADD, 32'h7fff_ffff, 32'd1);  // overflow
        queue_op(OP_SUB, 32'h8000_0000, 32'd1);  // overflow
        queue_op(OP_SUB, 32'd3, 32'd10);
        queue_op(OP_AND, 32'hf0f0_1234, 32'h0ff0_ffff);
        queue_op(OP_OR, 32'h1200_0034, 32'h0056_7800);
        queue_op(OP_XOR, 32'haaaa_5555, 32'hffff_0000);
        queue_op(OP_SLT, 32'hffff_ffff, 32'd1);
        queue_op(OP_SLT, 32'd1, 32'hffff_ffff);
        queue_op(OP_SW, 32'h10 - 32'hdead_beef, 32'hdead_beef);
        queue_op(OP_LW, 32'h10, '0);
        queue_op(OP_SW, 32'h12 - 32'h1234_5678, 32'h1234_5678);  // misaligned store
        queue_op(OP_LW, 32'h10, '0);
        queue_op(OP_LW, 32'h0c, 32'd1);
        queue_op(OP_MULT, 32'hffff_fffd, 32'd7);
        queue_op(OP_MFHI, '0, '0);
        queue_op(OP_MFLO, '0, '0);
        queue_op(OP_MULT, 32'h1234_5678, 32'h9abc_def0);
        queue_op(OP_MFHI, '0, '0);
        queue_op(OP_MFLO, '0, '0);
        queue_op(OP_MTHI, 32'hcafe_f00d, '0);
        queue_op(OP_MFHI, '0, '0);
        queue_op(OP_MTLO, 32'h0bad_f00d, '0);
        queue_op(OP_MFLO, '0, '0);
        repeat (N_RAND_TIMED) queue_random_op();
        timed_phase = 1'b1;
        drive_ops(1'b0);
        wait_drained();

        timed_phase = 1'b0;
        repeat (N_RAND_NOISY) queue_random_op();
        drive_ops(1'b1);
        wait_drained();
        repeat (5) @(negedge clk_i);

        if (squash_cnt == 0) begin
            abort_run("the random flushes never squashed an operation");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("timeout, the pipeline stopped retiring operations");
    end

endmodule

`default_nettype wire

// ==== ex_mem_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_cfg.svh"

module ex_mem_sva
    import mips_pkg::*;
(
    input logic                   clk_i,
    input logic                   rst_i,
    input logic                   flush_i,
    input logic                   iss_valid_i,
    input logic                   iss_ready_i,
    input logic                   wb_valid_i,
    input logic                   wb_ready_i,
    input logic [`REG_ADDR_W-1:0] wb_dest_i,
    input logic                   wb_we_i,
    input logic [`DATA_W-1:0]     wb_data_i,
    input logic [`DATA_W-1:0]     wb_pc_i,
    input exc_e                   wb_exc_i
);

    logic [2:0] in_flight;  // accepted, not yet taken at the writeback port
    logic       iss_fire;
    logic       wb_fire;

    assign iss_fire = iss_valid_i && iss_ready_i;
    assign wb_fire  = wb_valid_i && wb_ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            in_flight <= '0;
        end else if (flush_i) begin
            in_flight <= {2'b00, wb_valid_i && !wb_ready_i};  // a stalled record survives
        end else begin
            in_flight <= in_flight + 3'(iss_fire) - 3'(wb_fire);
        end
    end

    wb_idle_in_reset: assert property (@(posedge clk_i) rst_i |=> !wb_valid_i)
        else $error("wb_valid_o high while in reset");

    wb_idle_after_reset: assert property (@(posedge clk_i)
        $fell(rst_i) |-> !wb_valid_i && iss_ready_i)
        else $error("pipeline not idle right after reset");

    // record held unchanged until the sink takes it
    wb_stable_on_stall: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_valid_i && !wb_ready_i |=> wb_valid_i
            && $stable({wb_dest_i, wb_we_i, wb_data_i, wb_pc_i, wb_exc_i}))
        else $error("writeback record changed or dropped while stalled");

    ready_when_empty: assert property (@(posedge clk_i) disable iff (rst_i)
        in_flight == '0 |-> iss_ready_i)
        else $error("iss_ready_o low with an empty pipeline");

endmodule

bind ex_mem_top ex_mem_sva u_sva (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .iss_valid_i  (iss_valid_i),
    .iss_ready_i  (iss_ready_o),
    .wb_valid_i   (wb_valid_o),
    .wb_ready_i   (wb_ready_i),
    .wb_dest_i    (wb_dest_o),
    .wb_we_i      (wb_we_o),
    .wb_data_i    (wb_data_o),
    .wb_pc_i      (wb_pc_o),
    .wb_exc_i     (wb_exc_o)
);

`default_nettype wire

// ==== ex_mem_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_cfg.svh"

module ex_mem_top
    import mips_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   flush_i,
    input  logic                   iss_valid_i,
    input  alu_op_e                iss_op_i,
    input  logic [`DATA_W-1:0]     iss_a_i,
    input  logic [`DATA_W-1:0]     iss_b_i,
    input  logic [`REG_ADDR_W-1:0] iss_dest_i,
    input  logic                   iss_we_i,
    input  logic [`DATA_W-1:0]     iss_pc_i,
    output logic                   iss_ready_o,
    output logic                   wb_valid_o,
    output logic [`REG_ADDR_W-1:0] wb_dest_o,
    output logic                   wb_we_o,
    output logic [`DATA_W-1:0]     wb_data_o,
    output logic [`DATA_W-1:0]     wb_pc_o,
    output exc_e                   wb_exc_o,
    input  logic                   wb_ready_i
);

    issue_pkt_t  iss_pkt;
    logic        idex_valid;
    issue_pkt_t  idex_pkt;
    logic        idex_ready;
    logic        alu_valid;
    ex_mem_pkt_t alu_pkt;
    logic        alu_ready;
    logic        exmem_valid;
    ex_mem_pkt_t exmem_pkt;
    logic        exmem_ready;

    assign iss_pkt = '{
        op:   iss_op_i,
        a:    iss_a_i,
        b:    iss_b_i,
        dest: iss_dest_i,
        we:   iss_we_i,
        pc:   iss_pc_i
    };

    stage_reg #(
        .payload_t(issue_pkt_t)
    ) id_ex (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .flush_i    (flush_i),
        .in_valid_i (iss_valid_i),
        .in_data_i  (iss_pkt),
        .in_ready_o (iss_ready_o),
        .out_valid_o(idex_valid),
        .out_data_o (idex_pkt),
        .out_ready_i(idex_ready)
    );

    alu_stage u_alu (
        .in_valid_i (idex_valid),
        .in_pkt_i   (idex_pkt),
        .in_ready_o (idex_ready),
        .out_valid_o(alu_valid),
        .out_pkt_o  (alu_pkt),
        .out_ready_i(alu_ready)
    );

    stage_reg #(
        .payload_t(ex_mem_pkt_t)
    ) ex_mem (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .flush_i    (flush_i),
        .in_valid_i (alu_valid),
        .in_data_i  (alu_pkt),
        .in_ready_o (alu_ready),
        .out_valid_o(exmem_valid),
        .out_data_o (exmem_pkt),
        .out_ready_i(exmem_ready)
    );

    mem_stage u_mem (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .flush_i   (flush_i),
        .in_valid_i(exmem_valid),
        .in_pkt_i  (exmem_pkt),
        .in_ready_o(exmem_ready),
        .wb_valid_o(wb_valid_o),
        .wb_dest_o (wb_dest_o),
        .wb_we_o   (wb_we_o),
        .wb_data_o (wb_data_o),
        .wb_pc_o   (wb_pc_o),
        .wb_exc_o  (wb_exc_o),
        .wb_ready_i(wb_ready_i)
    );

endmodule

`default_nettype wire

// ==== mem_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_cfg.svh"

module mem_stage
    import mips_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   flush_i,
    input  logic                   in_valid_i,
    input  ex_mem_pkt_t            in_pkt_i,
    output logic                   in_ready_o,
    output logic                   wb_valid_o,
    output logic [`REG_ADDR_W-1:0] wb_dest_o,
    output logic                   wb_we_o,
    output logic [`DATA_W-1:0]     wb_data_o,
    output logic [`DATA_W-1:0]     wb_pc_o,
    output exc_e                   wb_exc_o,
    input  logic                   wb_ready_i
);

    localparam int DMEM_AW = $clog2(`DMEM_DEPTH);

    logic [`DATA_W-1:0] dmem [`DMEM_DEPTH];
    logic [`DATA_W-1:0] hi_q;
    logic [`DATA_W-1:0] lo_q;
    logic [DMEM_AW-1:0] word_idx;
    logic [`DATA_W-1:0] wb_data_d;
    logic               accept;
    logic               commit;

    assign in_ready_o = !wb_valid_o || wb_ready_i;
    assign accept     = in_valid_i && in_ready_o && !flush_i;  // flushed op dropped here
    assign commit     = accept && (in_pkt_i.exc == EXC_NONE);
    assign word_idx   = in_pkt_i.addr[DMEM_AW+1:2];

    // writeback value, sampled before this edge's own updates
    always_comb begin
        if (in_pkt_i.rmem && in_pkt_i.exc == EXC_NONE) begin
            wb_data_d = dmem[word_idx];
        end else if (in_pkt_i.mf_hi) begin
            wb_data_d = hi_q;
        end else if (in_pkt_i.mf_lo) begin
            wb_data_d = lo_q;
        end else begin
            wb_data_d = in_pkt_i.result[`DATA_W-1:0];
        end
    end

    // architectural side effects
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hi_q <= '0;
            lo_q <= '0;
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (commit) begin
            if (in_pkt_i.wmem) begin
                dmem[word_idx] <= in_pkt_i.wdata;
            end
            if (in_pkt_i.mt_hi) begin
                hi_q <= in_pkt_i.result[2*`DATA_W-1:`DATA_W];
            end
            if (in_pkt_i.mt_lo) begin
                lo_q <= in_pkt_i.result[`DATA_W-1:0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
        end else if (accept) begin
            wb_valid_o <= 1'b1;
        end else if (wb_ready_i) begin
            wb_valid_o <= 1'b0;  // record taken, nothing new
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            wb_dest_o <= in_pkt_i.dest;
            wb_we_o   <= in_pkt_i.we;
            wb_data_o <= wb_data_d;
            wb_pc_o   <= in_pkt_i.pc;
            wb_exc_o  <= in_pkt_i.exc;
        end
    end

endmodule

`default_nettype wire

// ==== alu_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_cfg.svh"

module alu_stage
    import mips_pkg::*;
(
    input  logic        in_valid_i,
    input  issue_pkt_t  in_pkt_i,
    output logic        in_ready_o,
    output logic        out_valid_o,
    output ex_mem_pkt_t out_pkt_o,
    input  logic        out_ready_i
);

    localparam int MSB = `DATA_W - 1;

    logic [`DATA_W-1:0]          a;
    logic [`DATA_W-1:0]          b;
    logic [`DATA_W-1:0]          sum;
    logic [`DATA_W-1:0]          diff;
    logic signed [2*`DATA_W-1:0] prod;
    logic                        ov_add;
    logic                        ov_sub;
    logic                        lt;
    logic                        misaligned;

    assign out_valid_o = in_valid_i;
    assign in_ready_o  = out_ready_i;

    assign a    = in_pkt_i.a;
    assign b    = in_pkt_i.b;
    assign sum  = a + b;  // also the load/store address
    assign diff = a - b;
    assign prod = $signed(a) * $signed(b);
    assign lt   = $signed(a) < $signed(b);

    assign ov_add     = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
    assign ov_sub     = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
    assign misaligned = (sum[1:0] != 2'b00);

    always_comb begin
        out_pkt_o      = '0;
        out_pkt_o.op   = in_pkt_i.op;
        out_pkt_o.dest = in_pkt_i.dest;
        out_pkt_o.we   = in_pkt_i.we;
        out_pkt_o.pc   = in_pkt_i.pc;
        out_pkt_o.addr = sum;
        out_pkt_o.wdata = b;  // store data from second operand
        case (in_pkt_i.op)
            OP_ADD: begin
                out_pkt_o.result[MSB:0] = sum;
                if (ov_add) begin
                    out_pkt_o.exc = EXC_OV;
                end
            end
            OP_SUB: begin
                out_pkt_o.result[MSB:0] = diff;
                if (ov_sub) begin
                    out_pkt_o.exc = EXC_OV;
                end
            end
            OP_AND:  out_pkt_o.result[MSB:0] = a & b;
            OP_OR:   out_pkt_o.result[MSB:0] = a | b;
            OP_XOR:  out_pkt_o.result[MSB:0] = a ^ b;
            OP_SLT:  out_pkt_o.result[MSB:0] = {{MSB{1'b0}}, lt};
            OP_MULT: begin
                out_pkt_o.result = prod;
                out_pkt_o.mt_hi  = 1'b1;
                out_pkt_o.mt_lo  = 1'b1;
            end
            OP_MTHI: begin
                out_pkt_o.result = {a, a};  // both halves so writeback shows a
                out_pkt_o.mt_hi  = 1'b1;
            end
            OP_MTLO: begin
                out_pkt_o.result = {a, a};
                out_pkt_o.mt_lo  = 1'b1;
            end
            OP_MFHI: out_pkt_o.mf_hi = 1'b1;
            OP_MFLO: out_pkt_o.mf_lo = 1'b1;
            OP_LW: begin
                out_pkt_o.result[MSB:0] = sum;
                out_pkt_o.rmem          = 1'b1;
                if (misaligned) begin
                    out_pkt_o.exc = EXC_ADEL;
                end
            end
            OP_SW: begin
                out_pkt_o.result[MSB:0] = sum;
                out_pkt_o.wmem          = 1'b1;
                if (misaligned) begin
                    out_pkt_o.exc = EXC_ADES;
                end
            end
            default: out_pkt_o.result = '0;
        endcase
        if (out_pkt_o.exc != EXC_NONE) begin
            out_pkt_o.we = 1'b0;  // faulting op never writes a register
        end
    end

endmodule

`default_nettype wire

// ==== stage_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module stage_reg
    import mips_pkg::*;
#(
    parameter type payload_t = issue_pkt_t
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     flush_i,
    input  logic     in_valid_i,
    input  payload_t in_data_i,
    output logic     in_ready_o,
    output logic     out_valid_o,
    output payload_t out_data_o,
    input  logic     out_ready_i
);

    logic load;

    assign in_ready_o = !out_valid_o || out_ready_i;  // empty or draining this edge
    assign load       = in_valid_i && in_ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            out_valid_o <= 1'b0;
        end else if (flush_i) begin
            out_valid_o <= 1'b0;  // squash wins over a load
        end else if (load) begin
            out_valid_o <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    // payload qualified by out_valid_o
    always_ff @(posedge clk_i) begin
        if (load) begin
            out_data_o <= in_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== mips_pkg.sv ====
`default_nettype none

`include "mips_cfg.svh"

package mips_pkg;

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLT  = 4'd5,
        OP_MULT = 4'd6,
        OP_MTHI = 4'd7,
        OP_MTLO = 4'd8,
        OP_MFHI = 4'd9,
        OP_MFLO = 4'd10,
        OP_LW   = 4'd11,
        OP_SW   = 4'd12
    } alu_op_e;

    typedef enum logic [1:0] {
        EXC_NONE = 2'd0,
        EXC_OV   = 2'd1,  // signed add/sub overflow
        EXC_ADEL = 2'd2,  // misaligned load
        EXC_ADES = 2'd3   // misaligned store
    } exc_e;

    typedef struct packed {
        alu_op_e                op;
        logic [`DATA_W-1:0]     a;
        logic [`DATA_W-1:0]     b;
        logic [`REG_ADDR_W-1:0] dest;
        logic                   we;
        logic [`DATA_W-1:0]     pc;
    } issue_pkt_t;

    typedef struct packed {
        alu_op_e                op;
        logic [`REG_ADDR_W-1:0] dest;
        logic                   we;
        logic [2*`DATA_W-1:0]   result;  // high half only for MULT/MTHI
        logic                   mt_hi;
        logic                   mt_lo;
        logic                   mf_hi;
        logic                   mf_lo;
        logic                   rmem;
        logic                   wmem;
        logic [`DATA_W-1:0]     addr;
        logic [`DATA_W-1:0]     wdata;
        logic [`DATA_W-1:0]     pc;
        exc_e                   exc;
    } ex_mem_pkt_t;

endpackage

`default_nettype wire

// ==== mips_cfg.svh ====
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// sizes shared by the execute and memory stages

// destination register number, 32 GPRs
`define REG_ADDR_W 5

// integer data word
`define DATA_W 32

// data RAM size in words, word addressed with byte address bits [1:0] dropped
`define DMEM_DEPTH 64

`endif
